//--- filelist.f
+incdir+dv
hdl/ladder_field_pkg.sv
hdl/ladder_bus_pkg.sv
hdl/fe_addsub.sv
hdl/fe_mul.sv
hdl/ladder_step.sv
hdl/ladder_ctrl.sv
hdl/ladder_apb_regs.sv
hdl/ladder_top.sv
dv/ladder_tb.sv

//--- dv/ladder_model.svh
`ifndef LADDER_MODEL_SVH
`define LADDER_MODEL_SVH

////////////////////////////////////////////////////////////
// reference field arithmetic, plain integers

// 16-bit field prime
localparam longint REF_P = 65521;
// curve constant folded into the field
localparam longint REF_A24 = 121665 % REF_P;

function automatic longint ref_add(input longint a, input longint b);
	return (a + b) % REF_P;
endfunction

// bias by p so the result never goes negative
function automatic longint ref_sub(input longint a, input longint b);
	return (a - b + REF_P) % REF_P;
endfunction

function automatic longint ref_mul(input longint a, input longint b);
	return (a * b) % REF_P;
endfunction

////////////////////////////////////////////////////////////
// reference ladder

// scalar MSB first, swap in and out per bit, returns {x2, z2}
function automatic logic [31:0] ref_ladder(input longint x1, input logic [15:0] k);
	longint x2, z2, x3, z3;
	longint a, aa, b, bb, e;
	longint c, d, da, cb;
	int i;
	x2 = 1;
	z2 = 0;
	x3 = x1;
	z3 = 1;
	for (i = 15; i >= 0; i--) begin
		if (k[i]) {x2, z2, x3, z3} = {x3, z3, x2, z2};
		a = ref_add(x2, z2);
		aa = ref_mul(a, a);
		b = ref_sub(x2, z2);
		bb = ref_mul(b, b);
		e = ref_sub(aa, bb);
		c = ref_add(x3, z3);
		d = ref_sub(x3, z3);
		da = ref_mul(d, a);
		cb = ref_mul(c, b);
		x3 = ref_mul(ref_add(da, cb), ref_add(da, cb));
		z3 = ref_mul(x1, ref_mul(ref_sub(da, cb), ref_sub(da, cb)));
		x2 = ref_mul(aa, bb);
		z2 = ref_mul(e, ref_add(aa, ref_mul(REF_A24, e)));
		// back to the unswapped order
		if (k[i]) {x2, z2, x3, z3} = {x3, z3, x2, z2};
	end
	return {x2[15:0], z2[15:0]};
endfunction

// 32-bit LCG, wraps naturally
function automatic int unsigned lcg_next(input int unsigned s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

`endif

//--- dv/ladder_tb.sv
`timescale 1ns/1ps

module ladder_tb;
	import ladder_bus_pkg::*;

	`include "ladder_model.svh"

	localparam int N_FIXED = 5;
	localparam int N_RAND = 5;
	localparam int N_ROWS = N_FIXED + N_RAND;
	// budget of 20 x 400 cycles per run plus one run for the busy test and bus traffic
	localparam int MAX_CYCLES = (N_ROWS + 1) * 20 * 400 + 2000;

	// one stimulus row with its expected result
	typedef struct packed {
		logic [15:0] x1;
		logic [15:0] scalar;
		logic [15:0] exp_x;
		logic [15:0] exp_z;
	} row_t;

	logic clk;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	row_t rows [N_ROWS];
	int cycles;
	int unsigned seed;
	logic err;

	ladder_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	always #10 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$fatal(1, "watchdog expired");
		end
	end

	////////////////////////////////////////////////////////////
	// helpers

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
			$display("Something failed");
			$fatal(1, "check failed");
		end
	endtask

	// setup phase then access phase with the response sampled mid low phase
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		output logic slverr);
		@(negedge clk);
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		apb_req.pwrite = 1'b1;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#5;
		slverr = apb_rsp.pslverr;
		check_eq(apb_rsp.pready, 1'b1, "pready in write access phase");
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic slverr);
		@(negedge clk);
		apb_req.paddr = addr;
		apb_req.pwrite = 1'b0;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#5;
		data = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		check_eq(apb_rsp.pready, 1'b1, "pready in read access phase");
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	// mapped write that must not flag an error
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic se;
		apb_write(addr, data, se);
		check_eq(se, 1'b0, $sformatf("pslverr on write to %h", addr));
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string msg);
		logic [31:0] d;
		logic se;
		apb_read(addr, d, se);
		check_eq(se, 1'b0, {msg, " pslverr"});
		check_eq(d, exp, msg);
	endtask

	// poll STATUS until the done bit shows
	task automatic wait_done();
		logic [31:0] st;
		logic se;
		st = '0;
		while (st[1] !== 1'b1) begin
			apb_read(REG_STATUS, st, se);
		end
	endtask

	function automatic row_t make_row(input logic [15:0] x1, input logic [15:0] k);
		row_t r;
		logic [31:0] xz;
		xz = ref_ladder(x1, k);
		r.x1 = x1;
		r.scalar = k;
		r.exp_x = xz[31:16];
		r.exp_z = xz[15:0];
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		apb_req = '0;
		cycles = 0;
		seed = 32'h2b3f;

		// fixed rows for edge scalars and the usual base
		rows[0] = make_row(16'd9, 16'h0000);
		rows[1] = make_row(16'd9, 16'h0001);
		rows[2] = make_row(16'd5, 16'hffff);
		rows[3] = make_row(16'd9, 16'h00c5);
		rows[4] = make_row(16'd65520, 16'h8001);
		// random rows with x1 kept below p
		for (int i = N_FIXED; i < N_ROWS; i++) begin
			seed = lcg_next(seed);
			rows[i].x1 = 16'((seed >> 8) % 65521);
			seed = lcg_next(seed);
			rows[i] = make_row(rows[i].x1, seed[23:8]);
		end

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// reset values
		read_check(REG_STATUS, 32'h0, "STATUS after reset");
		read_check(REG_RES_X, 32'h0, "RES_X after reset");
		read_check(REG_RES_Z, 32'h0, "RES_Z after reset");

		// readback of the inputs
		write_reg(REG_X1, 32'h1234);
		write_reg(REG_SCALAR, 32'hbeef);
		read_check(REG_X1, 32'h1234, "X1 readback");
		read_check(REG_SCALAR, 32'hbeef, "SCALAR readback");

		// one full run per row
		for (int i = 0; i < N_ROWS; i++) begin
			write_reg(REG_X1, rows[i].x1);
			write_reg(REG_SCALAR, rows[i].scalar);
			write_reg(REG_CTRL, 32'h1);
			wait_done();
			read_check(REG_RES_X, rows[i].exp_x, $sformatf("row %0d RES_X", i));
			read_check(REG_RES_Z, rows[i].exp_z, $sformatf("row %0d RES_Z", i));
		end

		// second start while busy is dropped
		write_reg(REG_X1, rows[2].x1);
		write_reg(REG_SCALAR, rows[2].scalar);
		write_reg(REG_CTRL, 32'h1);
		// other inputs waiting, a restart would pick them up
		write_reg(REG_X1, rows[3].x1);
		write_reg(REG_SCALAR, rows[3].scalar);
		read_check(REG_STATUS, 32'h1, "STATUS busy before second start");
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		read_check(REG_STATUS, 32'h2, "STATUS after busy run");
		// no hidden second run
		repeat (40) @(negedge clk);
		read_check(REG_STATUS, 32'h2, "STATUS stays idle");
		read_check(REG_RES_X, rows[2].exp_x, "busy run RES_X");
		read_check(REG_RES_Z, rows[2].exp_z, "busy run RES_Z");

		// unmapped and read-only accesses
		begin
			logic [31:0] d;
			apb_read(8'h18, d, err);
			check_eq(err, 1'b1, "pslverr on unmapped read");
			apb_write(8'h20, 32'hffff, err);
			check_eq(err, 1'b1, "pslverr on unmapped write");
			apb_write(8'h09, 32'h0, err);
			check_eq(err, 1'b1, "pslverr on misaligned write");
			apb_write(REG_STATUS, 32'h3, err);
			check_eq(err, 1'b1, "pslverr on STATUS write");
			apb_write(REG_RES_X, 32'h0, err);
			check_eq(err, 1'b1, "pslverr on RES_X write");
			apb_write(REG_RES_Z, 32'h0, err);
			check_eq(err, 1'b1, "pslverr on RES_Z write");
		end
		// nothing moved
		read_check(REG_X1, rows[3].x1, "X1 after bad accesses");
		read_check(REG_SCALAR, rows[3].scalar, "SCALAR after bad accesses");
		read_check(REG_RES_X, rows[2].exp_x, "RES_X after bad accesses");
		read_check(REG_RES_Z, rows[2].exp_z, "RES_Z after bad accesses");
		read_check(REG_STATUS, 32'h2, "STATUS after bad accesses");

		$display("Everything OK");
		$finish;
	end

endmodule

//--- hdl/ladder_top.sv
`timescale 1ns/1ps

module ladder_top (
	input logic clk,
	input logic rst_n,
	input ladder_bus_pkg::apb_req_t apb_req,
	output ladder_bus_pkg::apb_rsp_t apb_rsp
);
	import ladder_field_pkg::*;

	// register block and controller
	logic start, busy, done;
	fe_t x1;
	logic [SCALAR_W-1:0] scalar;
	xz_t result;

	// controller and step
	logic step_start, step_b, step_done;
	fe_t step_x1;
	xz_t step_p2, step_p3, step_p2_new, step_p3_new;

	// shared arithmetic
	logic mul_start, mul_done, as_en, as_valid;
	fe_t mul_a, mul_b, mul_y, as_a, as_b, as_y;
	fe_op_t as_op;

	ladder_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.start(start), .x1(x1), .scalar(scalar),
		.busy(busy), .done(done), .result(result)
	);

	ladder_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .x1(x1), .scalar(scalar),
		.busy(busy), .done(done), .result(result),
		.step_start(step_start), .step_b(step_b), .step_x1(step_x1),
		.step_p2(step_p2), .step_p3(step_p3), .step_done(step_done),
		.step_p2_new(step_p2_new), .step_p3_new(step_p3_new)
	);

	ladder_step u_step (
		.clk(clk), .rst_n(rst_n), .start(step_start), .b(step_b), .x1(step_x1),
		.p2_in(step_p2), .p3_in(step_p3), .done(step_done),
		.p2_out(step_p2_new), .p3_out(step_p3_new),
		.mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
		.mul_done(mul_done), .mul_y(mul_y),
		.as_en(as_en), .as_op(as_op), .as_a(as_a), .as_b(as_b),
		.as_valid(as_valid), .as_y(as_y)
	);

	fe_mul u_mul (
		.clk(clk), .rst_n(rst_n), .start(mul_start), .a(mul_a), .b(mul_b),
		.done(mul_done), .y(mul_y)
	);

	fe_addsub u_addsub (
		.clk(clk), .rst_n(rst_n), .en(as_en), .op(as_op), .a(as_a), .b(as_b),
		.valid(as_valid), .y(as_y)
	);

endmodule

//--- hdl/ladder_apb_regs.sv
`timescale 1ns/1ps

module ladder_apb_regs (
	input logic clk,
	input logic rst_n,
	input ladder_bus_pkg::apb_req_t apb_req,
	output ladder_bus_pkg::apb_rsp_t apb_rsp,
	output logic start,
	output ladder_field_pkg::fe_t x1,
	output logic [ladder_field_pkg::SCALAR_W-1:0] scalar,
	input logic busy,
	input logic done,
	input ladder_field_pkg::xz_t result
);
	import ladder_field_pkg::*;
	import ladder_bus_pkg::*;

	logic done_q;
	fe_t res_x;
	fe_t res_z;

	logic access;
	logic mapped;
	logic read_only;
	logic wr_ok;
	logic [31:0] rdata;

	////////////////////////////////////////////////////////////
	// address decode

	always_comb begin
		mapped = 1'b1;
		read_only = 1'b0;
		rdata = '0;
		case (apb_req.paddr)
			// ctrl reads back as zero
			REG_CTRL: ;
			REG_STATUS: begin
				read_only = 1'b1;
				rdata = {{30{1'b0}}, done_q, busy};
			end
			REG_X1: rdata = {{(32-FE_W){1'b0}}, x1};
			REG_SCALAR: rdata = {{(32-SCALAR_W){1'b0}}, scalar};
			REG_RES_X: begin
				read_only = 1'b1;
				rdata = {{(32-FE_W){1'b0}}, res_x};
			end
			REG_RES_Z: begin
				read_only = 1'b1;
				rdata = {{(32-FE_W){1'b0}}, res_z};
			end
			default: mapped = 1'b0;
		endcase
	end

	// access phase only, no wait states
	assign access = apb_req.psel && apb_req.penable;
	assign wr_ok = access && apb_req.pwrite && mapped && !read_only;

	always_comb begin
		apb_rsp.prdata = rdata;
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));
	end

	assign start = wr_ok && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0] && !busy;

	////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x1 <= '0;
			scalar <= '0;
			done_q <= 1'b0;
			res_x <= '0;
			res_z <= '0;
		end else begin
			if (wr_ok && (apb_req.paddr == REG_X1)) x1 <= apb_req.pwdata[FE_W-1:0];
			if (wr_ok && (apb_req.paddr == REG_SCALAR)) begin
				scalar <= apb_req.pwdata[SCALAR_W-1:0];
			end
			// sticky until the next run
			if (start) done_q <= 1'b0;
			else if (done) done_q <= 1'b1;
			if (done) begin
				res_x <= result.x;
				res_z <= result.z;
			end
		end
	end

endmodule

//--- hdl/ladder_ctrl.sv
`timescale 1ns/1ps

module ladder_ctrl (
	input logic clk,
	input logic rst_n,
	input logic start,
	input ladder_field_pkg::fe_t x1,
	input logic [ladder_field_pkg::SCALAR_W-1:0] scalar,
	output logic busy,
	output logic done,
	output ladder_field_pkg::xz_t result,
	output logic step_start,
	output logic step_b,
	output ladder_field_pkg::fe_t step_x1,
	output ladder_field_pkg::xz_t step_p2,
	output ladder_field_pkg::xz_t step_p3,
	input logic step_done,
	input ladder_field_pkg::xz_t step_p2_new,
	input ladder_field_pkg::xz_t step_p3_new
);
	import ladder_field_pkg::*;

	// current scalar bit, counts down
	bit_idx_t idx;
	logic [SCALAR_W-1:0] k_q;
	fe_t x1_q;
	xz_t p2;
	xz_t p3;

	logic launch;

	// start while busy is dropped
	assign launch = start && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			step_start <= 1'b0;
			idx <= '0;
		end else begin
			done <= 1'b0;
			step_start <= 1'b0;
			if (launch) begin
				busy <= 1'b1;
				step_start <= 1'b1;
				idx <= bit_idx_t'(SCALAR_W - 1);
			end else if (busy && step_done) begin
				if (idx == '0) begin
					// LSB finished
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					idx <= idx - 1'b1;
					step_start <= 1'b1;
				end
			end
		end
	end

	// p2 = (1, 0) neutral, p3 = (x1, 1) base
	always_ff @(posedge clk) begin
		if (launch) begin
			k_q <= scalar;
			x1_q <= x1;
			p2 <= '{x: fe_t'(1), z: '0};
			p3 <= '{x: x1, z: fe_t'(1)};
		end else if (busy && step_done) begin
			p2 <= step_p2_new;
			p3 <= step_p3_new;
		end
	end

	assign step_b = k_q[idx];
	assign step_x1 = x1_q;
	assign step_p2 = p2;
	assign step_p3 = p3;
	assign result = p2;

endmodule

//--- hdl/ladder_step.sv
`timescale 1ns/1ps

module ladder_step (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic b,
	input ladder_field_pkg::fe_t x1,
	input ladder_field_pkg::xz_t p2_in,
	input ladder_field_pkg::xz_t p3_in,
	output logic done,
	output ladder_field_pkg::xz_t p2_out,
	output ladder_field_pkg::xz_t p3_out,
	output logic mul_start,
	output ladder_field_pkg::fe_t mul_a,
	output ladder_field_pkg::fe_t mul_b,
	input logic mul_done,
	input ladder_field_pkg::fe_t mul_y,
	output logic as_en,
	output ladder_field_pkg::fe_op_t as_op,
	output ladder_field_pkg::fe_t as_a,
	output ladder_field_pkg::fe_t as_b,
	input logic as_valid,
	input ladder_field_pkg::fe_t as_y
);
	import ladder_field_pkg::*;

	typedef enum logic [4:0] {
		ST_IDLE, ST_A, ST_B, ST_C, ST_D, ST_AA, ST_BB, ST_DA, ST_CB,
		ST_SUM, ST_X2, ST_X3, ST_Z3A, ST_Z3, ST_G, ST_H, ST_Z2
	} state_t;

	state_t state;
	state_t state_nxt;

	// pairs after the input select
	xz_t q2;
	xz_t q3;
	logic b_q;

	// RFC 7748 temporaries
	fe_t a_v, b_v, c_v, d_v;
	fe_t aa, bb, e, da, cb;
	fe_t sum_v, dif_v;
	fe_t x2_n, x3_n, z3_n;

	////////////////////////////////////////////////////////////
	// issue to the shared units, next state

	always_comb begin
		state_nxt = state;
		mul_start = 1'b0;
		mul_a = '0;
		mul_b = '0;
		as_en = 1'b0;
		as_op = FE_ADD;
		as_a = '0;
		as_b = '0;
		case (state)
			ST_IDLE: if (start) state_nxt = ST_A;
			// A = x2 + z2
			ST_A: begin
				as_en = 1'b1;
				as_a = q2.x;
				as_b = q2.z;
				state_nxt = ST_B;
			end
			// B = x2 - z2, AA = A^2 starts on the fresh A
			ST_B: begin
				as_en = 1'b1;
				as_op = FE_SUB;
				as_a = q2.x;
				as_b = q2.z;
				mul_start = 1'b1;
				mul_a = as_y;
				mul_b = as_y;
				state_nxt = ST_C;
			end
			// C and D run under the AA multiply
			ST_C: begin
				as_en = 1'b1;
				as_a = q3.x;
				as_b = q3.z;
				state_nxt = ST_D;
			end
			ST_D: begin
				as_en = 1'b1;
				as_op = FE_SUB;
				as_a = q3.x;
				as_b = q3.z;
				state_nxt = ST_AA;
			end
			// BB = B^2
			ST_AA: if (mul_done) begin
				mul_start = 1'b1;
				mul_a = b_v;
				mul_b = b_v;
				state_nxt = ST_BB;
			end
			// E = AA - BB, then DA = D * A
			ST_BB: if (mul_done) begin
				as_en = 1'b1;
				as_op = FE_SUB;
				as_a = aa;
				as_b = mul_y;
				mul_start = 1'b1;
				mul_a = d_v;
				mul_b = a_v;
				state_nxt = ST_DA;
			end
			// CB = C * B
			ST_DA: if (mul_done) begin
				mul_start = 1'b1;
				mul_a = c_v;
				mul_b = b_v;
				state_nxt = ST_CB;
			end
			// DA + CB, and x2 = AA * BB meanwhile
			ST_CB: if (mul_done) begin
				as_en = 1'b1;
				as_a = da;
				as_b = mul_y;
				mul_start = 1'b1;
				mul_a = aa;
				mul_b = bb;
				state_nxt = ST_SUM;
			end
			ST_SUM: begin
				as_en = 1'b1;
				as_op = FE_SUB;
				as_a = da;
				as_b = cb;
				state_nxt = ST_X2;
			end
			// x3 = (DA + CB)^2
			ST_X2: if (mul_done) begin
				mul_start = 1'b1;
				mul_a = sum_v;
				mul_b = sum_v;
				state_nxt = ST_X3;
			end
			// (DA - CB)^2
			ST_X3: if (mul_done) begin
				mul_start = 1'b1;
				mul_a = dif_v;
				mul_b = dif_v;
				state_nxt = ST_Z3A;
			end
			// z3 = x1 * (DA - CB)^2
			ST_Z3A: if (mul_done) begin
				mul_start = 1'b1;
				mul_a = mul_y;
				mul_b = x1;
				state_nxt = ST_Z3;
			end
			// a24 * E
			ST_Z3: if (mul_done) begin
				mul_start = 1'b1;
				mul_a = A24;
				mul_b = e;
				state_nxt = ST_G;
			end
			// AA + a24 * E
			ST_G: if (mul_done) begin
				as_en = 1'b1;
				as_a = aa;
				as_b = mul_y;
				state_nxt = ST_H;
			end
			// z2 = E * (AA + a24 * E)
			ST_H: begin
				mul_start = 1'b1;
				mul_a = e;
				mul_b = as_y;
				state_nxt = ST_Z2;
			end
			ST_Z2: if (mul_done) state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			done <= 1'b0;
		end else begin
			state <= state_nxt;
			done <= (state == ST_Z2) && mul_done;
		end
	end

	////////////////////////////////////////////////////////////
	// capture of intermediate values

	always_ff @(posedge clk) begin
		case (state)
			// cswap on the way in
			ST_IDLE: if (start) begin
				q2 <= b ? p3_in : p2_in;
				q3 <= b ? p2_in : p3_in;
				b_q <= b;
			end
			ST_B: a_v <= as_y;
			ST_C: b_v <= as_y;
			ST_D: c_v <= as_y;
			ST_AA: begin
				// D lands in the first cycle here
				if (as_valid) d_v <= as_y;
				if (mul_done) aa <= mul_y;
			end
			ST_BB: if (mul_done) bb <= mul_y;
			ST_DA: begin
				if (as_valid) e <= as_y;
				if (mul_done) da <= mul_y;
			end
			ST_CB: if (mul_done) cb <= mul_y;
			ST_SUM: sum_v <= as_y;
			ST_X2: begin
				if (as_valid) dif_v <= as_y;
				if (mul_done) x2_n <= mul_y;
			end
			ST_X3: if (mul_done) x3_n <= mul_y;
			ST_Z3: if (mul_done) z3_n <= mul_y;
			// cswap on the way out, z2 straight from the multiplier
			ST_Z2: if (mul_done) begin
				p2_out <= b_q ? '{x: x3_n, z: z3_n} : '{x: x2_n, z: mul_y};
				p3_out <= b_q ? '{x: x2_n, z: mul_y} : '{x: x3_n, z: z3_n};
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/fe_mul.sv
`timescale 1ns/1ps

module fe_mul (
	input logic clk,
	input logic rst_n,
	input logic start,
	input ladder_field_pkg::fe_t a,
	input ladder_field_pkg::fe_t b,
	output logic done,
	output ladder_field_pkg::fe_t y
);
	import ladder_field_pkg::*;

	logic busy;
	mul_cnt_t cnt;
	fe_t a_q;
	// multiplier bits, shifted out at the top
	fe_t b_q;
	fe_t acc;
	fe_t acc_nxt;

	logic [FE_W:0] dbl;
	logic [FE_W:0] dbl_red;
	logic [FE_W:0] sum;

	// one double-and-add step per cycle
	always_comb begin
		dbl = {acc, 1'b0};
		dbl_red = (dbl >= (FE_W+1)'(P_MOD)) ? dbl - (FE_W+1)'(P_MOD) : dbl;
		sum = dbl_red + (b_q[FE_W-1] ? {1'b0, a_q} : '0);
		acc_nxt = (sum >= (FE_W+1)'(P_MOD)) ? fe_t'(sum - (FE_W+1)'(P_MOD)) : fe_t'(sum);
	end

	////////////////////////////////////////////////////////////
	// sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= mul_cnt_t'(FE_W);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				// last bit consumed this cycle
				if (cnt == mul_cnt_t'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// operands and accumulator
	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= a;
			b_q <= b;
			acc <= '0;
		end else if (busy) begin
			acc <= acc_nxt;
			b_q <= {b_q[FE_W-2:0], 1'b0};
		end
	end

	// held until the next start
	assign y = acc;

endmodule

//--- hdl/fe_addsub.sv
`timescale 1ns/1ps

module fe_addsub (
	input logic clk,
	input logic rst_n,
	input logic en,
	input ladder_field_pkg::fe_op_t op,
	input ladder_field_pkg::fe_t a,
	input ladder_field_pkg::fe_t b,
	output logic valid,
	output ladder_field_pkg::fe_t y
);
	import ladder_field_pkg::*;

	// one extra bit for carry / borrow
	logic [FE_W:0] sum;
	logic [FE_W:0] dif;
	logic [FE_W:0] res;

	always_comb begin
		sum = {1'b0, a} + {1'b0, b};
		dif = {1'b0, a} - {1'b0, b};
		if (op == FE_ADD) begin
			// a + b < 2p, one subtract is enough
			res = (sum >= (FE_W+1)'(P_MOD)) ? sum - (FE_W+1)'(P_MOD) : sum;
		end else begin
			// borrow wraps, adding p back lands in range
			res = (a < b) ? dif + (FE_W+1)'(P_MOD) : dif;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else begin
			valid <= en;
		end
	end

	// result register
	always_ff @(posedge clk) begin
		if (en) begin
			y <= res[FE_W-1:0];
		end
	end

endmodule

//--- hdl/ladder_bus_pkg.sv
package ladder_bus_pkg;

	////////////////////////////////////////////////////////////
	// apb signal bundles

	// master to slave
	typedef struct packed {
		logic [7:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	// slave to master
	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	////////////////////////////////////////////////////////////
	// register map

	// bit 0 written as 1 starts a run
	localparam logic [7:0] REG_CTRL = 8'h00;
	// bit 0 busy, bit 1 done, read only
	localparam logic [7:0] REG_STATUS = 8'h04;
	// base x-coordinate
	localparam logic [7:0] REG_X1 = 8'h08;
	localparam logic [7:0] REG_SCALAR = 8'h0C;
	// projective result, read only
	localparam logic [7:0] REG_RES_X = 8'h10;
	localparam logic [7:0] REG_RES_Z = 8'h14;

endpackage

//--- hdl/ladder_field_pkg.sv
package ladder_field_pkg;

	////////////////////////////////////////////////////////////
	// field parameters

	// width of one field element
	localparam int FE_W = 16;

	// scalar walked by the ladder, MSB first
	localparam int SCALAR_W = 16;

	// largest 16-bit prime
	localparam int unsigned P_MOD = 65521;

	// iteration counter of the multiplier, holds 0..FE_W
	localparam int MUL_CNT_W = $clog2(FE_W + 1);

	////////////////////////////////////////////////////////////
	// types

	typedef logic [FE_W-1:0] fe_t;
	typedef logic [MUL_CNT_W-1:0] mul_cnt_t;
	typedef logic [$clog2(SCALAR_W)-1:0] bit_idx_t;

	// projective point, x on top
	typedef struct packed {
		fe_t x;
		fe_t z;
	} xz_t;

	typedef enum logic {
		FE_ADD = 1'b0,
		FE_SUB = 1'b1
	} fe_op_t;

	// 121665 mod 65521
	localparam fe_t A24 = fe_t'(56144);

endpackage
